/* pgm_mem.f */
source/ddram_pkg.sv
source/arb_pkg.sv
source/rom_loader.sv
source/ddram_arbiter.sv
source/cpu_rom_reader.sv
source/pgm_mem_top.sv
tb/pgm_mem_props.sv
tb/tb_pgm_mem.sv

/* Makefile */
TOP = tb_pgm_mem

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) \
		-f pgm_mem.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* tb/tb_pgm_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_pgm_mem;

    import ddram_pkg::*;
    import arb_pkg::*;

    localparam logic [31:0] SEED = 32'd16522;
    localparam int RESET_CYCLES = 3;
    localparam int N_LOAD       = 24;   // Index 0 writes
    localparam int N_SKIP       = 6;    // Writes with another index
    localparam int N_RAND       = 40;   // Random reads after the download
    localparam int AUDIO_HOLD   = 8;    // Cycles sound_rd stays high after its ack
    localparam int TXN_CYCLES   = 40;   // Worst case for one transfer with busy and response delay
    localparam int NUM_TXN      = N_LOAD + N_SKIP + N_RAND + 8;
    localparam int CYCLE_LIMIT  = 10 * (NUM_TXN * (TXN_CYCLES + AUDIO_HOLD) + RESET_CYCLES);

    logic        fixed_50m_clk;
    logic        reset;
    logic        ioctl_download;
    logic        ioctl_wr;
    ioctl_addr_t ioctl_addr;
    ioctl_data_t ioctl_dout;
    logic [7:0]  ioctl_index;
    logic        ioctl_wait;
    logic        cpu_req;
    cpu_addr_t   cpu_addr;
    logic        cpu_ack;
    cpu_word_t   cpu_data;
    logic        vid_rd;
    ddram_addr_t vid_addr;
    logic        vid_ack;
    logic        sound_rd;
    ddram_addr_t sound_addr;
    logic        sound_ack;
    logic        ddram_rd;
    logic        ddram_we;
    ddram_addr_t ddram_addr;
    ddram_data_t ddram_din;
    ddram_be_t   ddram_be;
    ddram_data_t ddram_dout       = '0;
    logic        ddram_busy       = 1'b0;
    logic        ddram_dout_ready = 1'b0;

    // DDRAM model state
    logic [31:0] model_seed = SEED ^ 32'h0000_5a5a;
    logic [31:0] stim_seed  = SEED;
    logic        rd_open    = 1'b0;      // Read accepted and not yet answered
    logic [3:0]  rd_wait    = 4'd0;
    ddram_addr_t rd_addr_open;
    ddram_addr_t rd_addr_q[$];           // Address of every read strobe
    ddram_addr_t wr_addr_q[$];           // Completed writes
    ddram_data_t wr_data_q[$];
    ddram_be_t   wr_be_q[$];
    int          cycle_count = 0;

    pgm_mem_top i_dut (.*);

    bind pgm_mem_top pgm_mem_props i_pgm_mem_props (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .ioctl_download(ioctl_download),
        .ioctl_wait    (ioctl_wait),
        .ddram_rd      (ddram_rd),
        .ddram_we      (ddram_we),
        .ddram_busy    (ddram_busy)
    );

    initial begin
        fixed_50m_clk = 1'b0;
        forever #10 fixed_50m_clk = ~fixed_50m_clk;   // 50 MHz
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_step(stim_seed);
        return stim_seed;
    endfunction

    // Model memory contents as a hash of the beat address
    function automatic ddram_data_t beat_for_addr(input ddram_addr_t a);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = lcg_step({3'b000, a} ^ SEED);
        hi = lcg_step(lo);
        return {hi, lo};
    endfunction

    // 16-bit lane enables per loader word index
    function automatic ddram_be_t lane_for(input logic [1:0] word_sel);
        case (word_sel)
            2'd0:    return 8'h03;
            2'd1:    return 8'h0C;
            2'd2:    return 8'h30;
            default: return 8'hC0;
        endcase
    endfunction

    // Word picked by A2:A1 with its bytes swapped for the big-endian CPU
    function automatic cpu_word_t swapped_word(input ddram_data_t beat, input logic [1:0] sel);
        ddram_data_t shifted;
        shifted = beat >> {sel, 4'b0000};
        return {shifted[7:0], shifted[15:8]};
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("%0t: %s", $time, what);
        stop_run();
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic expect_addr(input string name, input ddram_addr_t got, input ddram_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic expect_data(input string name, input ddram_data_t got, input ddram_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic expect_be(input string name, input ddram_be_t got, input ddram_be_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic expect_word(input string name, input cpu_word_t got, input cpu_word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // DDRAM model with random busy and delayed read answers
    always @(posedge fixed_50m_clk) begin
        model_seed = lcg_step(model_seed);
        if (reset) begin
            ddram_busy       <= 1'b0;
            ddram_dout_ready <= 1'b0;
            rd_open          <= 1'b0;
        end else begin
            ddram_busy       <= (model_seed[31:30] == 2'b00);   // Busy about one cycle in four
            ddram_dout_ready <= 1'b0;
            if (ddram_rd) begin
                if (ddram_busy) report_problem("Read strobe while the DDRAM was busy");
                if (ioctl_download) report_problem("Read strobe during a download");
                if (rd_open) report_problem("Second read strobe before the first was answered");
                rd_addr_q.push_back(ddram_addr);
                rd_addr_open <= ddram_addr;
                rd_open      <= 1'b1;
                rd_wait      <= {1'b0, model_seed[27:25]} + 4'd1;
            end else if (rd_open) begin
                if (rd_wait == 4'd0) begin
                    ddram_dout_ready <= 1'b1;
                    ddram_dout       <= beat_for_addr(rd_addr_open);
                    rd_open          <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 4'd1;
                end
            end
            if (ddram_rd && ddram_we) report_problem("DDRAM read and write strobes high together");
            if (ddram_we && !ioctl_wait) report_problem("DDRAM write without ioctl_wait");
            if (ddram_we && !ddram_busy) begin   // Write taken this cycle
                wr_addr_q.push_back(ddram_addr);
                wr_data_q.push_back(ddram_din);
                wr_be_q.push_back(ddram_be);
            end
        end
    end

    always @(posedge fixed_50m_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) report_problem("Timeout, the run went past its cycle budget");
    end

    task automatic load_write(input logic [7:0] idx, input ioctl_addr_t a, input ioctl_data_t d);
        int wr_before;
        wr_before = wr_addr_q.size();
        ioctl_index <= idx;
        ioctl_addr  <= a;
        ioctl_dout  <= d;
        ioctl_wr    <= 1'b1;
        @(posedge fixed_50m_clk);
        ioctl_wr <= 1'b0;
        @(posedge fixed_50m_clk);
        if (idx == LOADER_ROM_INDEX) begin
            expect_bit("ioctl_wait", ioctl_wait, 1'b1);
            while (ioctl_wait) @(posedge fixed_50m_clk);
            if (wr_addr_q.size() != wr_before + 1)
                report_problem("Loader write did not give exactly one DDRAM write");
            expect_addr("ddram_addr", wr_addr_q[wr_before], {5'b0, a[26:3]});
            expect_data("ddram_din", wr_data_q[wr_before], {d, d, d, d});
            expect_be("ddram_be", wr_be_q[wr_before], lane_for(a[2:1]));
        end else begin
            repeat (4) begin
                @(posedge fixed_50m_clk);
                expect_bit("ioctl_wait", ioctl_wait, 1'b0);
            end
            if (wr_addr_q.size() != wr_before) report_problem("Write with another index hit DDRAM");
        end
    endtask

    task automatic cpu_read(input cpu_addr_t a);
        int rd_before;
        rd_before = rd_addr_q.size();
        cpu_addr <= a;
        cpu_req  <= 1'b1;
        @(posedge fixed_50m_clk);
        while (!cpu_ack) @(posedge fixed_50m_clk);
        if (rd_addr_q.size() != rd_before + 1) report_problem("CPU grant without exactly one strobe");
        expect_addr("ddram_addr", rd_addr_q[rd_before], {8'b0, a[23:3]});
        expect_word("cpu_data", cpu_data, swapped_word(beat_for_addr({8'b0, a[23:3]}), a[2:1]));
        cpu_req <= 1'b0;
        @(posedge fixed_50m_clk);
        while (cpu_ack) @(posedge fixed_50m_clk);
    endtask

    task automatic video_read(input ddram_addr_t a);
        int rd_before;
        rd_before = rd_addr_q.size();
        vid_addr <= a;
        vid_rd   <= 1'b1;
        @(posedge fixed_50m_clk);
        while (!vid_ack) @(posedge fixed_50m_clk);
        if (rd_addr_q.size() != rd_before + 1) report_problem("Video grant without exactly one strobe");
        expect_addr("ddram_addr", rd_addr_q[rd_before], a);
        vid_rd <= 1'b0;
        @(posedge fixed_50m_clk);
        while (vid_ack) @(posedge fixed_50m_clk);
    endtask

    // Held request must not start a second fetch
    task automatic audio_read(input ddram_addr_t a);
        int rd_before;
        rd_before = rd_addr_q.size();
        sound_addr <= a;
        sound_rd   <= 1'b1;
        @(posedge fixed_50m_clk);
        while (!sound_ack) @(posedge fixed_50m_clk);
        expect_addr("ddram_addr", rd_addr_q[rd_before], a);
        repeat (AUDIO_HOLD) begin
            @(posedge fixed_50m_clk);
            expect_bit("sound_ack", sound_ack, 1'b1);
        end
        if (rd_addr_q.size() != rd_before + 1) report_problem("Held sound_rd gave a second read");
        sound_rd <= 1'b0;
        @(posedge fixed_50m_clk);
        @(posedge fixed_50m_clk);
        expect_bit("sound_ack", sound_ack, 1'b0);
    endtask

    // CPU strobe goes first when CPU and video are raised together
    task automatic cpu_video_race(input cpu_addr_t ca, input ddram_addr_t va);
        int rd_before;
        rd_before = rd_addr_q.size();
        cpu_addr <= ca;
        vid_addr <= va;
        cpu_req  <= 1'b1;
        vid_rd   <= 1'b1;
        @(posedge fixed_50m_clk);
        while (!cpu_ack) @(posedge fixed_50m_clk);
        if (rd_addr_q.size() != rd_before + 1) report_problem("CPU did not win the first strobe");
        expect_addr("ddram_addr", rd_addr_q[rd_before], {8'b0, ca[23:3]});
        expect_word("cpu_data", cpu_data, swapped_word(beat_for_addr({8'b0, ca[23:3]}), ca[2:1]));
        cpu_req <= 1'b0;
        while (!vid_ack) @(posedge fixed_50m_clk);
        if (rd_addr_q.size() != rd_before + 2) report_problem("Video grant without exactly one strobe");
        expect_addr("ddram_addr", rd_addr_q[rd_before + 1], va);
        vid_rd <= 1'b0;
        @(posedge fixed_50m_clk);
        while (cpu_ack || vid_ack) @(posedge fixed_50m_clk);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        reset          <= 1'b1;
        ioctl_download <= 1'b0;
        ioctl_wr       <= 1'b0;
        ioctl_addr     <= '0;
        ioctl_dout     <= '0;
        ioctl_index    <= '0;
        cpu_req        <= 1'b0;
        cpu_addr       <= '0;
        vid_rd         <= 1'b0;
        vid_addr       <= '0;
        sound_rd       <= 1'b0;
        sound_addr     <= '0;
        repeat (RESET_CYCLES) @(posedge fixed_50m_clk);
        reset <= 1'b0;
        @(posedge fixed_50m_clk);
        expect_bit("ddram_rd", ddram_rd, 1'b0);
        expect_bit("ddram_we", ddram_we, 1'b0);
        expect_bit("ioctl_wait", ioctl_wait, 1'b0);
        expect_bit("cpu_ack", cpu_ack, 1'b0);
        expect_bit("vid_ack", vid_ack, 1'b0);
        expect_bit("sound_ack", sound_ack, 1'b0);
        expect_be("ddram_be", ddram_be, BE_ALL);

        // Download with a CPU request parked on the bus
        ioctl_download <= 1'b1;
        cpu_addr       <= 23'h01_2345;
        cpu_req        <= 1'b1;
        @(posedge fixed_50m_clk);
        for (int i = 0; i < N_LOAD + N_SKIP; i++) begin
            r  = next_rand();
            r2 = next_rand();
            if (i % 5 == 4) load_write(8'd1 + {5'b0, r2[2:0]}, r[26:0], r2[31:16]);
            else load_write(LOADER_ROM_INDEX, r[26:0], r2[31:16]);
        end
        cpu_req <= 1'b0;
        repeat (2) @(posedge fixed_50m_clk);
        ioctl_download <= 1'b0;
        @(posedge fixed_50m_clk);

        for (int w = 0; w < 4; w++) cpu_read({21'h00_1234, w[1:0]});   // Every word of a beat
        cpu_video_race(23'h2a_5553, 29'h0abc_def0);
        audio_read(29'h1357_9bdf);
        video_read(29'h0246_8ace);

        for (int i = 0; i < N_RAND; i++) begin
            r  = next_rand();
            r2 = next_rand();
            case (r[31:30])
                2'd0, 2'd1: cpu_read(r2[22:0]);
                2'd2:       video_read(r2[28:0]);
                default:    audio_read(r2[28:0]);
            endcase
            repeat (r[1:0]) @(posedge fixed_50m_clk);   // Idle gap
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/pgm_mem_props.sv */
`timescale 1ns/10ps
`default_nettype none

module pgm_mem_props (
    input wire fixed_50m_clk,
    input wire reset,
    input wire ioctl_download,
    input wire ioctl_wait,
    input wire ddram_rd,
    input wire ddram_we,
    input wire ddram_busy
);

    // Strobe only while the DDRAM can take it
    rd_not_busy: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_rd |-> !ddram_busy)
        else $error("ddram_rd high while ddram_busy high");

    rd_one_cycle: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_rd |=> !ddram_rd)   // One strobe per grant
        else $error("ddram_rd held for more than one cycle");

    rd_we_apart: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        !(ddram_rd && ddram_we))
        else $error("ddram_rd and ddram_we high together");

    // Loader stalls the HPS for the whole write
    we_holds_wait: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_we |-> ioctl_wait)
        else $error("ddram_we high without ioctl_wait");

    no_rd_loading: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ioctl_download |-> !ddram_rd)
        else $error("ddram_rd high during a download");

endmodule

`default_nettype wire

/* source/pgm_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pgm_mem_top (
    input  wire                         fixed_50m_clk,
    input  wire                         reset,

    // HPS download
    input  wire                         ioctl_download,
    input  wire                         ioctl_wr,
    input  wire ddram_pkg::ioctl_addr_t ioctl_addr,
    input  wire ddram_pkg::ioctl_data_t ioctl_dout,
    input  wire logic [7:0]             ioctl_index,
    output logic                        ioctl_wait,

    // CPU ROM port
    input  wire                         cpu_req,
    input  wire ddram_pkg::cpu_addr_t   cpu_addr,
    output logic                        cpu_ack,
    output ddram_pkg::cpu_word_t        cpu_data,

    // Video and audio requesters
    input  wire                         vid_rd,
    input  wire ddram_pkg::ddram_addr_t vid_addr,
    output logic                        vid_ack,
    input  wire                         sound_rd,
    input  wire ddram_pkg::ddram_addr_t sound_addr,
    output logic                        sound_ack,

    // DDRAM port
    output logic                        ddram_rd,
    output logic                        ddram_we,
    output ddram_pkg::ddram_addr_t      ddram_addr,
    output ddram_pkg::ddram_data_t      ddram_din,
    output ddram_pkg::ddram_be_t        ddram_be,
    input  wire ddram_pkg::ddram_data_t ddram_dout,
    input  wire                         ddram_busy,
    input  wire                         ddram_dout_ready
);

    import ddram_pkg::*;

    logic        wr_pending;
    ddram_addr_t wr_addr;
    ddram_data_t wr_data;
    ddram_be_t   wr_be;
    logic        cpu_fill;

    assign ioctl_wait = wr_pending;   // HPS stalls until the write is taken
    assign ddram_din  = wr_data;

    rom_loader i_rom_loader (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .ioctl_download(ioctl_download),
        .ioctl_wr      (ioctl_wr),
        .ioctl_addr    (ioctl_addr),
        .ioctl_dout    (ioctl_dout),
        .ioctl_index   (ioctl_index),
        .ddram_busy    (ddram_busy),
        .wr_pending    (wr_pending),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_be         (wr_be)
    );

    ddram_arbiter i_ddram_arbiter (
        .fixed_50m_clk   (fixed_50m_clk),
        .reset           (reset),
        .ioctl_download  (ioctl_download),
        .cpu_req         (cpu_req),
        .cpu_addr        (cpu_addr),
        .cpu_ack         (cpu_ack),
        .vid_rd          (vid_rd),
        .vid_addr        (vid_addr),
        .vid_ack         (vid_ack),
        .sound_rd        (sound_rd),
        .sound_addr      (sound_addr),
        .sound_ack       (sound_ack),
        .wr_pending      (wr_pending),
        .wr_addr         (wr_addr),
        .wr_be           (wr_be),
        .ddram_busy      (ddram_busy),
        .ddram_dout_ready(ddram_dout_ready),
        .cpu_fill        (cpu_fill),
        .ddram_rd        (ddram_rd),
        .ddram_we        (ddram_we),
        .ddram_addr      (ddram_addr),
        .ddram_be        (ddram_be)
    );

    cpu_rom_reader i_cpu_rom_reader (
        .fixed_50m_clk(fixed_50m_clk),
        .cpu_fill     (cpu_fill),
        .ddram_dout   (ddram_dout),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data)
    );

endmodule

`default_nettype wire

/* source/cpu_rom_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_rom_reader (
    input  wire                         fixed_50m_clk,
    input  wire                         cpu_fill,
    input  wire ddram_pkg::ddram_data_t ddram_dout,
    input  wire ddram_pkg::cpu_addr_t   cpu_addr,
    output ddram_pkg::cpu_word_t        cpu_data
);

    import ddram_pkg::*;

    ddram_data_t rom_beat;   // Last beat fetched for the CPU
    cpu_word_t   rom_word;

    always_ff @(posedge fixed_50m_clk) begin
        if (cpu_fill) begin
            rom_beat <= ddram_dout;
        end
    end

    // A2:A1 picks the word inside the beat
    always_comb begin
        case (cpu_addr[2:1])
            2'd0:    rom_word = rom_beat[15:0];
            2'd1:    rom_word = rom_beat[31:16];
            2'd2:    rom_word = rom_beat[47:32];
            default: rom_word = rom_beat[63:48];
        endcase
    end

    // ROM image is little-endian, 68k wants big-endian
    assign cpu_data = {rom_word[7:0], rom_word[15:8]};

endmodule

`default_nettype wire

/* source/ddram_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module ddram_arbiter (
    input  wire                         fixed_50m_clk,
    input  wire                         reset,
    input  wire                         ioctl_download,

    // CPU ROM fetch, level handshake
    input  wire                         cpu_req,
    input  wire ddram_pkg::cpu_addr_t   cpu_addr,
    output logic                        cpu_ack,

    // Video fetch, level handshake
    input  wire                         vid_rd,
    input  wire ddram_pkg::ddram_addr_t vid_addr,
    output logic                        vid_ack,

    // Audio fetch, edge request and held ack
    input  wire                         sound_rd,
    input  wire ddram_pkg::ddram_addr_t sound_addr,
    output logic                        sound_ack,

    // Loader write latch
    input  wire                         wr_pending,
    input  wire ddram_pkg::ddram_addr_t wr_addr,
    input  wire ddram_pkg::ddram_be_t   wr_be,

    input  wire                         ddram_busy,
    input  wire                         ddram_dout_ready,

    output logic                        cpu_fill,     // Capture strobe for the CPU reader
    output logic                        ddram_rd,
    output logic                        ddram_we,
    output ddram_pkg::ddram_addr_t      ddram_addr,
    output ddram_pkg::ddram_be_t        ddram_be
);

    import ddram_pkg::*;
    import arb_pkg::*;

    arb_state_t arb_state;
    logic       rd_issued;       // Read strobe already sent for this grant
    logic       sound_rd_last;
    logic       sound_rise;

    assign sound_rise = sound_rd && !sound_rd_last;

    // One strobe per grant, held off by busy and by the loader
    assign ddram_rd = !ioctl_download && (arb_state != ARB_IDLE) && !rd_issued && !ddram_busy;

    assign cpu_fill = !ioctl_download && (arb_state == ARB_CPU) && ddram_dout_ready;

    // Write side comes straight from the loader latch
    assign ddram_we = wr_pending;
    assign ddram_be = wr_pending ? wr_be : BE_ALL;

    // Address mux, loader owns the bus during a download
    always_comb begin
        if (ioctl_download) begin
            ddram_addr = wr_addr;
        end else begin
            case (arb_state)
                ARB_CPU:   ddram_addr = ddram_addr_t'(cpu_addr[23:3]);  // 8-byte beats
                ARB_AUDIO: ddram_addr = sound_addr;
                default:   ddram_addr = vid_addr;
            endcase
        end
    end

    // Audio edge detect
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            sound_rd_last <= 1'b0;
        end else begin
            sound_rd_last <= sound_rd;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            arb_state <= ARB_IDLE;
            rd_issued <= 1'b0;
            cpu_ack   <= 1'b0;
            vid_ack   <= 1'b0;
        end else if (ioctl_download) begin
            arb_state <= ARB_IDLE;           // Reads parked while loading
            rd_issued <= 1'b0;
        end else begin
            case (arb_state)
                ARB_IDLE: begin
                    rd_issued <= 1'b0;
                    // Acks drop only once the requester lets go
                    if (!cpu_req) cpu_ack <= 1'b0;
                    if (!vid_rd)  vid_ack <= 1'b0;
                    // No new grant while the previous ack is still up
                    if (cpu_req && !cpu_ack) begin
                        arb_state <= ARB_CPU;
                    end else if (vid_rd && !vid_ack) begin
                        arb_state <= ARB_VIDEO;
                    end else if (sound_rise) begin
                        arb_state <= ARB_AUDIO;
                    end
                end

                ARB_CPU: begin
                    if (ddram_rd) rd_issued <= 1'b1;
                    if (ddram_dout_ready) begin
                        cpu_ack   <= 1'b1;   // Beat captured by the reader this cycle
                        arb_state <= ARB_IDLE;
                    end
                end

                ARB_VIDEO: begin
                    if (ddram_rd) rd_issued <= 1'b1;
                    if (ddram_dout_ready) begin
                        vid_ack   <= 1'b1;
                        arb_state <= ARB_IDLE;
                    end
                end

                default: begin               // ARB_AUDIO
                    if (ddram_rd) rd_issued <= 1'b1;
                    if (ddram_dout_ready) arb_state <= ARB_IDLE;
                end
            endcase
        end
    end

    // Held ack for the audio side
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            sound_ack <= 1'b0;
        end else if (!ioctl_download && (arb_state == ARB_AUDIO) && ddram_dout_ready) begin
            sound_ack <= 1'b1;
        end else if (!sound_rd) begin
            sound_ack <= 1'b0;               // Released only by the requester
        end
    end

endmodule

`default_nettype wire

/* source/rom_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_loader (
    input  wire                         fixed_50m_clk,
    input  wire                         reset,
    input  wire                         ioctl_download,
    input  wire                         ioctl_wr,
    input  wire ddram_pkg::ioctl_addr_t ioctl_addr,
    input  wire ddram_pkg::ioctl_data_t ioctl_dout,
    input  wire logic [7:0]             ioctl_index,
    input  wire                         ddram_busy,
    output logic                        wr_pending,   // Also drives ioctl_wait and ddram_we
    output ddram_pkg::ddram_addr_t      wr_addr,
    output ddram_pkg::ddram_data_t      wr_data,
    output ddram_pkg::ddram_be_t        wr_be
);

    import ddram_pkg::*;
    import arb_pkg::*;

    logic wr_accept;

    // Only main ROM writes land in DDRAM, one at a time
    assign wr_accept = ioctl_download && ioctl_wr &&
                       (ioctl_index == LOADER_ROM_INDEX) && !wr_pending;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            wr_pending <= 1'b0;              // End of download drops any leftover write
        end else if (wr_accept) begin
            wr_pending <= 1'b1;
        end else if (wr_pending && !ddram_busy) begin
            wr_pending <= 1'b0;              // Write taken this cycle
        end
    end

    // Single-entry write latch
    // Held steady while the DDRAM reports busy
    always_ff @(posedge fixed_50m_clk) begin
        if (wr_accept) begin
            wr_addr <= ddram_addr_t'(ioctl_addr[IOCTL_ADDR_W-1:3]);  // Byte to beat address
            wr_data <= {4{ioctl_dout}};      // Same word on every lane
            // Word index picks the lane pair
            wr_be   <= BE_LANE_LOW << {ioctl_addr[2:1], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* source/arb_pkg.sv */
`default_nettype none

package arb_pkg;

    // Read arbiter states, one per requester
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,   // Waiting for a request
        ARB_CPU   = 2'd1,   // Main CPU ROM fetch
        ARB_VIDEO = 2'd2,   // Video engine fetch
        ARB_AUDIO = 2'd3    // Sample fetch, lowest priority
    } arb_state_t;

    // ioctl index of the main program ROM download
    localparam logic [7:0] LOADER_ROM_INDEX = 8'd0;

endpackage

`default_nettype wire

/* source/ddram_pkg.sv */
`default_nettype none

package ddram_pkg;

    // DDRAM port geometry
    localparam int DDRAM_ADDR_W = 29;              // 64-bit word address
    localparam int DDRAM_DATA_W = 64;
    localparam int DDRAM_BE_W   = DDRAM_DATA_W / 8;

    // Loader and CPU side
    localparam int IOCTL_ADDR_W = 27;              // Byte address from the HPS
    localparam int IOCTL_DATA_W = 16;
    localparam int CPU_WORD_W   = 16;

    typedef logic [DDRAM_ADDR_W-1:0] ddram_addr_t;
    typedef logic [DDRAM_DATA_W-1:0] ddram_data_t;
    typedef logic [DDRAM_BE_W-1:0]   ddram_be_t;
    typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
    typedef logic [IOCTL_DATA_W-1:0] ioctl_data_t;
    typedef logic [23:1]             cpu_addr_t;   // 68k word address, A0 not driven
    typedef logic [CPU_WORD_W-1:0]   cpu_word_t;

    localparam ddram_be_t BE_ALL      = '1;        // Reads always fetch the whole beat
    // Lowest 16-bit lane, moved up by two bits per word index
    localparam ddram_be_t BE_LANE_LOW = 8'h03;

endpackage

`default_nettype wire
